// File: armModePkg.sv
`default_nettype none

package armModePkg;

  // Architectural mode encodings
  typedef enum logic [4:0] {
    modeUsr = 5'b10000,
    modeFiq = 5'b10001,
    modeIrq = 5'b10010,
    modeSvc = 5'b10011,
    modeAbt = 5'b10111,
    modeUnd = 5'b11011,
    modeSys = 5'b11111
  } procMode;

  typedef struct packed {
    logic [3:0]  flags;      // N Z C V
    logic [18:0] reserved;
    logic        abortMask;  // Bit 8
    logic        irqMask;
    logic        fiqMask;
    logic        thumb;
    procMode     mode;       // Bits 4:0
  } psrWord;

  // Saved register slot of each exception mode
  typedef enum logic [2:0] {
    bankSvc  = 3'd0,
    bankAbt  = 3'd1,
    bankUnd  = 3'd2,
    bankIrq  = 3'd3,
    bankFiq  = 3'd4,
    bankNone = 3'd7  // usr, sys or a bad code
  } bankIdx;

  function automatic bankIdx modeBank(procMode m);
    case (m)
      modeSvc: return bankSvc;
      modeAbt: return bankAbt;
      modeUnd: return bankUnd;
      modeIrq: return bankIrq;
      modeFiq: return bankFiq;
      default: return bankNone;
    endcase
  endfunction

  // True for the seven defined modes only
  function automatic logic modeLegal(logic [4:0] code);
    case (code)
      modeUsr, modeFiq, modeIrq, modeSvc,
      modeAbt, modeUnd, modeSys: return 1'b1;
      default:                   return 1'b0;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: psrCtrlPkg.sv
`default_nettype none

package psrCtrlPkg;

  import armModePkg::*;

  // Same bit order as the writeback exception bus, fiq in bit 0
  typedef struct packed {
    logic undef;
    logic swi;
    logic prefetchAbort;
    logic dataAbort;
    logic irq;
    logic fiq;
  } excVector;

  typedef struct packed {
    logic       toSpsr;     // Target the saved register
    logic [3:0] fieldMask;  // One bit per byte lane
  } msrCtrl;

  // Byte lane positions inside fieldMask
  localparam int LaneControl   = 0;  // Bits 7:0
  localparam int LaneExtension = 1;  // Bits 15:8
  localparam int LaneStatus    = 2;  // Bits 23:16
  localparam int LaneFlags     = 3;  // Bits 31:24

  typedef struct packed {
    logic    take;
    procMode targetMode;
    bankIdx  bank;         // Where the old word is saved
    logic    useNewFlags;  // Save freshly selected flags
    logic    setFiqMask;
  } excEntry;

  // Writeback actions, listed in no priority order
  typedef enum logic [2:0] {
    actHold,
    actException,
    actMsrCpsr,
    actMsrSpsr,
    actRestore,
    actFlags
  } psrAction;

endpackage

`default_nettype wire

// File: exceptionPrioritizer.sv
`default_nettype none

module exceptionPrioritizer (
  input  psrCtrlPkg::excVector Exc,
  input  armModePkg::procMode  CurMode,
  output psrCtrlPkg::excEntry  Entry
);

  import armModePkg::*;
  import psrCtrlPkg::*;

  // Fill in one entry descriptor for a target mode
  function automatic excEntry describe(procMode target, logic newFlags, logic maskFiq);
    excEntry e;
    e.take        = 1'b1;
    e.targetMode  = target;
    e.bank        = modeBank(target);
    e.useNewFlags = newFlags;  // Late exceptions keep the last flag result
    e.setFiqMask  = maskFiq;
    return e;
  endfunction

  // Fixed priority walk
  // An exception aimed at the current mode drops out and the next one is tried
  always_comb begin
    Entry = '{
      take:        1'b0,
      targetMode:  CurMode,
      bank:        bankNone,
      useNewFlags: 1'b0,
      setFiqMask:  1'b0
    };
    if (Exc.dataAbort && CurMode != modeAbt) begin
      Entry = describe(modeAbt, 1'b1, 1'b0);
    end else if (Exc.fiq && CurMode != modeFiq) begin
      Entry = describe(modeFiq, 1'b1, 1'b1);  // Only fiq masks fiq
    end else if (Exc.irq && CurMode != modeIrq) begin
      Entry = describe(modeIrq, 1'b1, 1'b0);
    end else if (Exc.prefetchAbort && CurMode != modeAbt) begin
      Entry = describe(modeAbt, 1'b0, 1'b0);  // Shares the abort bank
    end else if (Exc.undef && CurMode != modeUnd) begin
      Entry = describe(modeUnd, 1'b0, 1'b0);
    end else if (Exc.swi && CurMode != modeSvc) begin
      Entry = describe(modeSvc, 1'b0, 1'b0);
    end
  end

  // Every taken exception must land in a banked mode
  assert final (!Entry.take || Entry.bank != bankNone)
    else $error("exception taken without a saved register bank");

endmodule

`default_nettype wire

// File: msrMerge.sv
`default_nettype none

module msrMerge (
  input  psrCtrlPkg::msrCtrl Ctrl,
  input  logic [31:0]        Operand,  // MSR source value
  input  armModePkg::psrWord Cpsr,
  input  armModePkg::psrWord CurSpsr,
  output armModePkg::psrWord MsrWord
);

  import armModePkg::*;
  import psrCtrlPkg::*;

  psrWord      oldWord;
  logic        privileged;
  logic [3:0]  laneWrite;
  logic [31:0] merged;

  // Old value of whichever register is written
  assign oldWord    = Ctrl.toSpsr ? CurSpsr : Cpsr;
  assign privileged = Cpsr.mode != modeUsr;  // sys counts as privileged

  // Flags lane open in every mode
  assign laneWrite[LaneFlags]     = Ctrl.fieldMask[LaneFlags];
  assign laneWrite[LaneStatus]    = Ctrl.fieldMask[LaneStatus] & privileged;
  assign laneWrite[LaneExtension] = Ctrl.fieldMask[LaneExtension] & privileged;
  assign laneWrite[LaneControl]   = Ctrl.fieldMask[LaneControl] & privileged;

  always_comb begin
    merged = oldWord;
    for (int lane = 0; lane < 4; lane++) begin
      if (laneWrite[lane]) begin
        merged[lane*8 +: 8] = Operand[lane*8 +: 8];
      end
    end
    // Bad mode code still updates the mask and thumb bits
    if (laneWrite[LaneControl] && !modeLegal(Operand[4:0])) begin
      merged[4:0] = oldWord.mode;
    end
  end

  assign MsrWord = psrWord'(merged);

  // Merge never turns a legal mode into an illegal one
  assert final (!modeLegal(oldWord.mode) || modeLegal(MsrWord.mode))
    else $error("MSR produced illegal mode %b", MsrWord.mode);

endmodule

`default_nettype wire

// File: spsrBank.sv
`default_nettype none

module spsrBank (
  input  logic                clk,
  input  logic                reset,
  input  logic                WriteEn,
  input  armModePkg::bankIdx  WriteIdx,
  input  armModePkg::psrWord  WriteData,
  input  armModePkg::procMode ReadMode,   // Current mode
  input  armModePkg::psrWord  Cpsr,       // Fallback when no bank exists
  output armModePkg::psrWord  ReadData
);

  import armModePkg::*;

  localparam int NumBanks = 5;  // svc abt und irq fiq

  psrWord bankQ [NumBanks];
  bankIdx readIdx;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NumBanks; i++) begin
        bankQ[i] <= '0;
      end
    end else if (WriteEn && WriteIdx != bankNone) begin
      bankQ[WriteIdx] <= WriteData;
    end
  end

  // usr and sys read back the current word
  assign readIdx  = modeBank(ReadMode);
  assign ReadData = (readIdx == bankNone) ? Cpsr : bankQ[readIdx];

  // Upstream action decode must never aim a write at a missing bank
  assert property (@(posedge clk) disable iff (reset) WriteEn |-> WriteIdx != bankNone)
    else $error("bank write with no target bank");

endmodule

`default_nettype wire

// File: statusRegister.sv
`default_nettype none

module statusRegister #(
  parameter armModePkg::procMode ResetMode = armModePkg::modeSvc
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                NotStallW,      // Write enable for all state
  input  logic [3:0]          FlagsNext,
  input  logic                FlagsWrite,
  input  logic                CoProcFlagUpd,
  input  logic [31:0]         Operand,        // ALU result
  input  psrCtrlPkg::msrCtrl  Msr,
  input  logic                RestoreCpsr,
  input  psrCtrlPkg::excEntry Entry,
  input  armModePkg::psrWord  MsrWord,
  output armModePkg::psrWord  Cpsr,
  output armModePkg::psrWord  CurSpsr
);

  import armModePkg::*;
  import psrCtrlPkg::*;

  // All interrupts masked, flags clear
  localparam psrWord ResetWord = '{
    flags:     4'b0000,
    reserved:  19'b0,
    abortMask: 1'b1,
    irqMask:   1'b1,
    fiqMask:   1'b1,
    thumb:     1'b0,
    mode:      ResetMode
  };

  psrWord     cpsrQ;
  psrWord     cpsrNext;
  psrWord     entryWord;
  psrWord     savedWord;
  psrAction   action;
  logic [3:0] flagsSel;
  logic [3:0] entryFlags;
  logic       hasSpsr;
  logic       msrValid;
  logic       bankWe;
  bankIdx     bankWrIdx;
  psrWord     bankWrData;

  // Coprocessor transfer takes flags straight off the ALU result
  assign flagsSel = CoProcFlagUpd ? Operand[31:28] : FlagsNext;
  assign hasSpsr  = modeBank(cpsrQ.mode) != bankNone;
  assign msrValid = Msr.fieldMask != 4'b0000;  // Empty mask is no MSR

  // Priority decode, ignored requests fall to hold
  always_comb begin
    if (Entry.take) begin
      action = actException;
    end else if (msrValid && !Msr.toSpsr) begin
      action = actMsrCpsr;
    end else if (msrValid) begin
      action = hasSpsr ? actMsrSpsr : actHold;  // No saved word in usr or sys
    end else if (RestoreCpsr) begin
      action = hasSpsr ? actRestore : actHold;
    end else if (FlagsWrite) begin
      action = actFlags;
    end else begin
      action = actHold;
    end
  end

  // Entry words
  assign entryFlags = Entry.useNewFlags ? flagsSel : cpsrQ.flags;

  always_comb begin
    savedWord       = cpsrQ;
    savedWord.flags = entryFlags;  // Old bits 27:0 kept as they are
    entryWord           = '0;      // Reserved, abort mask and thumb cleared
    entryWord.flags     = entryFlags;
    entryWord.irqMask   = 1'b1;
    entryWord.fiqMask   = Entry.setFiqMask | cpsrQ.fiqMask;
    entryWord.mode      = Entry.targetMode;
  end

  always_comb begin
    cpsrNext   = cpsrQ;
    bankWe     = 1'b0;
    bankWrIdx  = modeBank(cpsrQ.mode);
    bankWrData = MsrWord;
    case (action)
      actException: begin
        cpsrNext   = entryWord;
        bankWe     = 1'b1;
        bankWrIdx  = Entry.bank;
        bankWrData = savedWord;
      end
      actMsrCpsr: cpsrNext = MsrWord;
      actMsrSpsr: bankWe   = 1'b1;      // Current mode's bank
      actRestore: cpsrNext = CurSpsr;
      actFlags:   cpsrNext.flags = flagsSel;
      default:    cpsrNext = cpsrQ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cpsrQ <= ResetWord;
    end else if (NotStallW) begin
      cpsrQ <= cpsrNext;
    end
  end

  assign Cpsr = cpsrQ;

  spsrBank bank0 (
    .clk       (clk),
    .reset     (reset),
    .WriteEn   (bankWe & NotStallW),
    .WriteIdx  (bankWrIdx),
    .WriteData (bankWrData),
    .ReadMode  (cpsrQ.mode),
    .Cpsr      (cpsrQ),
    .ReadData  (CurSpsr)
  );

  // Only a restore of a never-written bank can leave the defined modes
  assert property (@(posedge clk) disable iff (reset)
      modeLegal(cpsrQ.mode) && !(NotStallW && action == actRestore)
      |=> modeLegal(cpsrQ.mode))
    else $error("current mode left the legal set");

endmodule

`default_nettype wire

// File: psrUnit.sv
`default_nettype none

module psrUnit #(
  parameter armModePkg::procMode ResetMode = armModePkg::modeSvc
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [3:0]           FlagsNext,
  input  logic                 FlagsWrite,
  input  logic [31:0]          AluOut,
  input  psrCtrlPkg::msrCtrl   Msr,
  input  psrCtrlPkg::excVector Exceptions,
  input  logic                 RestoreCpsr,
  input  logic                 NotStallW,
  input  logic                 CoProcFlagUpd,
  output armModePkg::psrWord   CpsrData,
  output armModePkg::psrWord   SpsrData
);

  import armModePkg::*;
  import psrCtrlPkg::*;

  excEntry entry;    // Exception entry descriptor
  psrWord  msrWord;  // Merged MSR result

  exceptionPrioritizer prio0 (
    .Exc     (Exceptions),
    .CurMode (CpsrData.mode),
    .Entry   (entry)
  );

  msrMerge merge0 (
    .Ctrl    (Msr),
    .Operand (AluOut),
    .Cpsr    (CpsrData),
    .CurSpsr (SpsrData),
    .MsrWord (msrWord)
  );

  statusRegister #(
    .ResetMode (ResetMode)
  ) status0 (
    .clk           (clk),
    .reset         (reset),
    .NotStallW     (NotStallW),
    .FlagsNext     (FlagsNext),
    .FlagsWrite    (FlagsWrite),
    .CoProcFlagUpd (CoProcFlagUpd),
    .Operand       (AluOut),
    .Msr           (Msr),
    .RestoreCpsr   (RestoreCpsr),
    .Entry         (entry),
    .MsrWord       (msrWord),
    .Cpsr          (CpsrData),
    .CurSpsr       (SpsrData)
  );

endmodule

`default_nettype wire

// File: psrUnitTb.sv
`default_nettype none

module psrUnitTb;

  timeunit 1ns;
  timeprecision 100ps;

  import armModePkg::*;
  import psrCtrlPkg::*;

  localparam int ClkPeriod      = 4;
  localparam int NumRandom      = 2000;
  localparam int DirectedCycles = 60;    // Generous bound for the directed part
  localparam int WatchMargin    = 400;   // ns

  // Architectural mode codes
  localparam logic [4:0] ModeUsr = 5'h10;
  localparam logic [4:0] ModeFiq = 5'h11;
  localparam logic [4:0] ModeIrq = 5'h12;
  localparam logic [4:0] ModeSvc = 5'h13;
  localparam logic [4:0] ModeAbt = 5'h17;
  localparam logic [4:0] ModeUnd = 5'h1B;
  localparam logic [4:0] ModeSys = 5'h1F;

  typedef struct packed {
    logic [3:0]  flagsNext;
    logic        flagsWrite;
    logic [31:0] alu;
    msrCtrl      msr;
    excVector    exc;
    logic        restore;
    logic        notStall;
    logic        coProc;
  } stimVec;

  typedef struct packed {
    logic [31:0]      cpsr;
    logic [4:0][31:0] banks;  // svc abt und irq fiq
  } modelState;

  logic        clk;
  logic        reset;
  stimVec      stim;
  string       phase;
  modelState   model;
  logic [31:0] seed;
  int          errorCount;
  int          checkCount;
  psrWord      CpsrData;
  psrWord      SpsrData;

  psrUnit #(
    .ResetMode (modeSvc)
  ) dut0 (
    .clk           (clk),
    .reset         (reset),
    .FlagsNext     (stim.flagsNext),
    .FlagsWrite    (stim.flagsWrite),
    .AluOut        (stim.alu),
    .Msr           (stim.msr),
    .Exceptions    (stim.exc),
    .RestoreCpsr   (stim.restore),
    .NotStallW     (stim.notStall),
    .CoProcFlagUpd (stim.coProc),
    .CpsrData      (CpsrData),
    .SpsrData      (SpsrData)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  function automatic logic [31:0] lcgNext(logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Bank slot of a mode or -1 when the mode has no bank
  function automatic int bankOf(logic [4:0] m);
    case (m)
      ModeSvc: return 0;
      ModeAbt: return 1;
      ModeUnd: return 2;
      ModeIrq: return 3;
      ModeFiq: return 4;
      default: return -1;
    endcase
  endfunction

  function automatic logic isMode(logic [4:0] m);
    return bankOf(m) >= 0 || m == ModeUsr || m == ModeSys;
  endfunction

  function automatic logic [4:0] pickMode(int idx);
    case (idx)
      0: return ModeUsr;
      1: return ModeFiq;
      2: return ModeIrq;
      3: return ModeSvc;
      4: return ModeAbt;
      5: return ModeUnd;
      default: return ModeSys;
    endcase
  endfunction

  // Lane merge onto the destination's old word
  function automatic logic [31:0] mergeMsr(logic [31:0] oldW, logic [4:0] curMode,
                                           logic [3:0] mask, logic [31:0] val);
    logic [31:0] r;
    logic        priv;
    r    = oldW;
    priv = curMode != ModeUsr;
    if (mask[3]) r[31:24] = val[31:24];
    if (mask[2] && priv) r[23:16] = val[23:16];
    if (mask[1] && priv) r[15:8] = val[15:8];
    if (mask[0] && priv) begin
      r[7:5] = val[7:5];
      if (isMode(val[4:0])) r[4:0] = val[4:0];  // Bad code keeps the mode
    end
    return r;
  endfunction

  function automatic modelState nextState(modelState s, stimVec v);
    modelState   n;
    logic [31:0] cur;
    logic [3:0]  fl;
    logic [3:0]  keepFl;
    logic [4:0]  tgt;
    logic        take;
    logic        newFl;
    logic        maskFiq;
    int          bk;
    n       = s;
    cur     = s.cpsr;
    take    = 1'b1;
    newFl   = 1'b0;
    maskFiq = 1'b0;
    tgt     = ModeSvc;
    if (!v.notStall) return s;  // Stall holds everything
    fl = v.coProc ? v.alu[31:28] : v.flagsNext;
    bk = bankOf(cur[4:0]);
    // dataAbort, fiq, irq, prefetchAbort, undef, swi
    if (v.exc.dataAbort && cur[4:0] != ModeAbt) begin
      tgt   = ModeAbt;
      newFl = 1'b1;
    end else if (v.exc.fiq && cur[4:0] != ModeFiq) begin
      tgt     = ModeFiq;
      newFl   = 1'b1;
      maskFiq = 1'b1;
    end else if (v.exc.irq && cur[4:0] != ModeIrq) begin
      tgt   = ModeIrq;
      newFl = 1'b1;
    end else if (v.exc.prefetchAbort && cur[4:0] != ModeAbt) tgt = ModeAbt;
    else if (v.exc.undef && cur[4:0] != ModeUnd) tgt = ModeUnd;
    else if (v.exc.swi && cur[4:0] != ModeSvc) tgt = ModeSvc;
    else take = 1'b0;
    keepFl = newFl ? fl : cur[31:28];
    if (take) begin
      n.banks[bankOf(tgt)] = {keepFl, cur[27:0]};
      n.cpsr = {keepFl, 19'b0, 1'b0, 1'b1, maskFiq | cur[6], 1'b0, tgt};
    end else if (v.msr.fieldMask != 4'b0000) begin
      if (!v.msr.toSpsr) n.cpsr = mergeMsr(cur, cur[4:0], v.msr.fieldMask, v.alu);
      else if (bk >= 0) n.banks[bk] = mergeMsr(s.banks[bk], cur[4:0], v.msr.fieldMask, v.alu);
    end else if (v.restore) begin
      if (bk >= 0) n.cpsr = s.banks[bk];  // usr and sys ignore restore
    end else if (v.flagsWrite) begin
      n.cpsr[31:28] = fl;
    end
    return n;
  endfunction

  function automatic logic [31:0] expectedSpsr(modelState s);
    int bk;
    bk = bankOf(s.cpsr[4:0]);
    return (bk < 0) ? s.cpsr : s.banks[bk];
  endfunction

  function automatic stimVec idleVec();
    stimVec v;
    v          = '0;
    v.notStall = 1'b1;
    return v;
  endfunction

  function automatic stimVec flagsOp(logic [3:0] fn, logic cp, logic [31:0] alu);
    stimVec v;
    v            = idleVec();
    v.flagsWrite = 1'b1;
    v.flagsNext  = fn;
    v.coProc     = cp;
    v.alu        = alu;
    return v;
  endfunction

  function automatic stimVec excOp(logic [5:0] bits, logic [3:0] fn);
    stimVec v;
    v           = idleVec();
    v.exc       = bits;  // undef swi pabt dabt irq fiq
    v.flagsNext = fn;
    return v;
  endfunction

  function automatic stimVec msrOp(logic toSpsr, logic [3:0] mask, logic [31:0] alu);
    stimVec v;
    v               = idleVec();
    v.msr.toSpsr    = toSpsr;
    v.msr.fieldMask = mask;
    v.alu           = alu;
    return v;
  endfunction

  function automatic stimVec restoreOp();
    stimVec v;
    v         = idleVec();
    v.restore = 1'b1;
    return v;
  endfunction

  task automatic checkWord(string name, logic [31:0] exp, logic [31:0] act);
    checkCount++;
    if (act !== exp) begin
      errorCount++;
      $display("mismatch %s expected %08h actual %08h", name, exp, act);
    end
  endtask

  task automatic drive(stimVec v, string name);
    @(posedge clk);
    stim  <= v;
    phase <= name;
  endtask

  // Model steps on each rising edge and the DUT is compared at the falling edge
  initial begin : compareProc
    string lblName;
    forever begin
      @(posedge clk);
      lblName = phase;  // Label of the inputs sampled at this edge
      if (reset) begin
        model.cpsr  = 32'h0000_01D3;  // Masks set in svc mode
        model.banks = '0;
      end else begin
        model = nextState(model, stim);
      end
      @(negedge clk);
      checkWord({lblName, " cpsr"}, model.cpsr, CpsrData);
      checkWord({lblName, " spsr"}, expectedSpsr(model), SpsrData);
    end
  end

  initial begin : watchdog
    #((NumRandom + DirectedCycles) * ClkPeriod + WatchMargin);
    $display("timeout: the run did not finish in the expected time");
    $display("checks %0d errors %0d", checkCount, errorCount);
    $display("tests failed");
    $finish;
  end

  initial begin : mainProc
    stimVec v;
    clk        = 1'b0;
    reset      = 1'b1;
    stim       = idleVec();
    phase      = "reset";
    seed       = 32'd98179;
    errorCount = 0;
    checkCount = 0;

    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    checkWord("reset cpsr", 32'h0000_01D3, CpsrData);
    checkWord("reset spsr", 32'h0, SpsrData);

    drive(flagsOp(4'hA, 1'b0, 32'h0), "flags");
    drive(flagsOp(4'h3, 1'b1, 32'h5000_0000), "flags");  // ALU nibble wins
    v          = flagsOp(4'hF, 1'b0, 32'h0);
    v.notStall = 1'b0;
    drive(v, "stall");
    v = excOp(6'b111111, 4'hC);
    v.notStall = 1'b0;
    drive(v, "stall");

    drive(excOp(6'b111111, 4'hC), "exception");  // dataAbort wins
    drive(excOp(6'b011100, 4'h9), "exception");  // Both aborts skipped in abt
    drive(excOp(6'b100010, 4'h6), "exception");  // irq before undef
    drive(msrOp(1'b0, 4'b0001, 32'h0000_0092), "exception");  // Clear the fiq mask
    drive(excOp(6'b000011, 4'h1), "exception");  // fiq masks fiq
    drive(excOp(6'b000001, 4'h7), "exception");  // Same mode, nothing taken
    drive(excOp(6'b001000, 4'h2), "exception");  // Old flags saved

    drive(msrOp(1'b0, 4'b0000, 32'hFFFF_FFFF), "msrCpsr");
    drive(msrOp(1'b0, 4'b0001, 32'h0000_00E5), "msrCpsr");  // Bad mode code
    drive(msrOp(1'b0, 4'b0110, 32'h00AB_CD00), "msrCpsr");
    drive(msrOp(1'b0, 4'b1001, 32'h9000_0010), "msrCpsr");  // Drop to usr
    drive(msrOp(1'b0, 4'b1111, 32'h6000_00D3), "msrCpsr");  // Flags lane only

    drive(msrOp(1'b1, 4'b1111, 32'hF000_0013), "msrSpsr");  // Ignored in usr
    drive(restoreOp(), "msrSpsr");
    drive(excOp(6'b010000, 4'h0), "msrSpsr");  // swi back to svc
    drive(msrOp(1'b1, 4'b1111, 32'hA000_001F), "msrSpsr");
    drive(msrOp(1'b1, 4'b0001, 32'h0000_0005), "msrSpsr");
    drive(restoreOp(), "restore");  // Into sys
    drive(msrOp(1'b1, 4'b1111, 32'h1234_5611), "restore");
    drive(restoreOp(), "restore");
    drive(idleVec(), "restore");

    for (int i = 0; i < NumRandom; i++) begin
      v = idleVec();
      seed = lcgNext(seed);
      v.notStall = (seed[31:16] % 5) != 0;
      seed = lcgNext(seed);
      if (seed[31:16] % 5 == 0) begin
        seed  = lcgNext(seed);
        v.exc = seed[21:16];
      end
      seed = lcgNext(seed);
      if (seed[31:16] % 5 == 0) begin
        seed            = lcgNext(seed);
        v.msr.toSpsr    = seed[16];
        v.msr.fieldMask = seed[20:17];
      end
      seed = lcgNext(seed);
      v.restore = (seed[31:16] % 8) == 0;
      seed = lcgNext(seed);
      v.flagsWrite = seed[16];
      v.flagsNext  = seed[20:17];
      v.coProc     = seed[21];
      seed  = lcgNext(seed);
      v.alu = seed;
      seed = lcgNext(seed);
      if (seed[31:16] % 4 != 0) v.alu[4:0] = pickMode(int'(seed[31:16] % 7));
      drive(v, "random");
    end

    drive(idleVec(), "drain");
    repeat (2) @(posedge clk);
    @(negedge clk);
    #1;
    $display("checks %0d errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
armModePkg.sv
psrCtrlPkg.sv
exceptionPrioritizer.sv
msrMerge.sv
spsrBank.sv
statusRegister.sv
psrUnit.sv
psrUnitTb.sv
